// File: design/idExPkg.sv
package idExPkg;

	////////////////////////////////////////
	// Instruction field positions
	////////////////////////////////////////
	localparam int opMsb          = 31;
	localparam int opLsb          = 26;
	localparam int rsMsb          = 25;
	localparam int rtMsb          = 20;
	localparam int rdMsb          = 15;
	localparam int immWidth       = 16;
	localparam int jumpIndexWidth = 26;
	localparam int regCount       = 32;
	// Destination of jal
	localparam logic [4:0] linkRegister = 5'd31;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////
	// Primary opcodes, standard MIPS values
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opSlti  = 6'h0a,
		opAndi  = 6'h0c,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnXor = 6'h26,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluLui,
		aluPass
	} aluOpT;

	// Write-back source
	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink
	} wbSelT;

	////////////////////////////////////////
	// Pipeline bundles
	////////////////////////////////////////
	typedef struct packed {
		aluOpT aluOp;
		logic  isJump;
		logic  isNotConditional;
		logic  isEq;
		logic  memWrite;
		logic  memRead;
		logic  aluSrc;
		logic  regDst;
		logic  regWrite;
		wbSelT wbSel;
	} ctrlT;

	typedef struct packed {
		ctrlT        ctrl;
		logic [31:0] pc;
		logic [31:0] reg1;
		logic [31:0] reg2;
		logic [31:0] imm;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [25:0] jumpIndex;
	} idExT;

	typedef struct packed {
		logic        regWrite;
		logic        memRead;
		logic        memWrite;
		wbSelT       wbSel;
		logic [4:0]  writeAddr;
		logic [31:0] aluResult;
		logic [31:0] storeData;
		logic [31:0] linkPc;
		logic        redirect;
		logic [31:0] redirectPc;
	} exWbT;

endpackage

// File: design/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import idExPkg::*; (
	input  opcodeT opcode,
	input  functT  funct,
	output ctrlT   ctrl
);

	always_comb
	begin
		// Inactive bundle, also the no-op
		ctrl       = '0;
		ctrl.aluOp = aluPass;
		ctrl.wbSel = wbAlu;
		case (opcode)
			opRtype:
			begin
				ctrl.regDst = 1'b1;
				// Unknown funct leaves the write off
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAdd:   ctrl.aluOp = aluAdd;
					fnSub:   ctrl.aluOp = aluSub;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnXor:   ctrl.aluOp = aluXor;
					fnSlt:   ctrl.aluOp = aluSlt;
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			opAddi, opAndi, opOri, opSlti, opLui:
			begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				case (opcode)
					opAndi:  ctrl.aluOp = aluAnd;
					opOri:   ctrl.aluOp = aluOr;
					opSlti:  ctrl.aluOp = aluSlt;
					opLui:   ctrl.aluOp = aluLui;
					default: ctrl.aluOp = aluAdd;
				endcase
			end
			opLw:
			begin
				// Address is base plus offset
				ctrl.aluOp    = aluAdd;
				ctrl.aluSrc   = 1'b1;
				ctrl.memRead  = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel    = wbMem;
			end
			opSw:
			begin
				ctrl.aluOp    = aluAdd;
				ctrl.aluSrc   = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opBeq, opBne:
			begin
				// Conditional, compare done in execute
				ctrl.aluOp  = aluSub;
				ctrl.isJump = 1'b1;
				ctrl.isEq   = (opcode == opBeq);
			end
			opJ, opJal:
			begin
				ctrl.isJump           = 1'b1;
				ctrl.isNotConditional = 1'b1;
				// jal links pc+4
				if (opcode == opJal)
				begin
					ctrl.regWrite = 1'b1;
					ctrl.wbSel    = wbLink;
				end
			end
			default:
			begin
				ctrl.aluOp = aluPass;
			end
		endcase
	end

endmodule

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile import idExPkg::*; (
	input  logic        clock,
	input  logic        arstN,
	input  logic [4:0]  readAddr1,
	input  logic [4:0]  readAddr2,
	input  logic        writeEnable,
	input  logic [4:0]  writeAddr,
	input  logic [31:0] writeData,
	output logic [31:0] readData1,
	output logic [31:0] readData2
);

	logic [31:0] regs [regCount];

	// Read port with write bypass, register zero fixed at zero
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		logic [31:0] value;
		if (addr == 5'd0)
			value = '0;
		else if (writeEnable && (writeAddr == addr))
			value = writeData;
		else
			value = regs[addr];
		return value;
	endfunction

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && (writeAddr != 5'd0))
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// Two identical combinational ports
	assign readData1 = readPort(readAddr1);
	assign readData2 = readPort(readAddr2);

endmodule

// File: design/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import idExPkg::*; (
	input  logic        clock,
	input  logic        arstN,
	input  logic [31:0] instr,
	input  logic [31:0] pc,
	input  exWbT        exWb,
	input  logic [31:0] loadData,
	output idExT        idEx,
	output logic        wbWrite,
	output logic [4:0]  wbAddr,
	output logic [31:0] wbData
);

	ctrlT        ctrl;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [31:0] imm;
	logic [31:0] reg1;
	logic [31:0] reg2;
	idExT        idExNext;

	////////////////////////////////////////
	// Field extraction
	////////////////////////////////////////
	assign rs  = instr[rsMsb -: 5];
	assign rt  = instr[rtMsb -: 5];
	assign rd  = instr[rdMsb -: 5];
	// Sign-extended 16-bit immediate
	assign imm = {{(32 - immWidth){instr[immWidth - 1]}}, instr[immWidth - 1:0]};

	controlDecoder controlDecoder_i (
		.opcode (opcodeT'(instr[opMsb:opLsb])),
		.funct  (functT'(instr[5:0])),
		.ctrl   (ctrl)
	);

	////////////////////////////////////////
	// Write-back from EX/WB
	////////////////////////////////////////
	always_comb
	begin
		case (exWb.wbSel)
			wbMem:   wbData = loadData;
			wbLink:  wbData = exWb.linkPc;
			default: wbData = exWb.aluResult;
		endcase
	end

	assign wbWrite = exWb.regWrite;
	assign wbAddr  = exWb.writeAddr;

	registerFile registerFile_i (
		.clock       (clock),
		.arstN       (arstN),
		.readAddr1   (rs),
		.readAddr2   (rt),
		.writeEnable (wbWrite),
		.writeAddr   (wbAddr),
		.writeData   (wbData),
		.readData1   (reg1),
		.readData2   (reg2)
	);

	// Next ID/EX contents
	always_comb
	begin
		idExNext.ctrl      = ctrl;
		idExNext.pc        = pc;
		idExNext.reg1      = reg1;
		idExNext.reg2      = reg2;
		idExNext.imm       = imm;
		idExNext.rs        = rs;
		idExNext.rt        = rt;
		idExNext.rd        = rd;
		idExNext.jumpIndex = instr[jumpIndexWidth - 1:0];
	end

	// ID/EX register
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			idEx <= '0;
		else
			idEx <= idExNext;
	end

endmodule

// File: design/executeStage.sv
`timescale 1ns/1ps

module executeStage import idExPkg::*; (
	input  logic clock,
	input  logic arstN,
	input  idExT idEx,
	output exWbT exWb
);

	ctrlT        ctrl;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] logicalImm;
	logic [31:0] aluResult;
	logic [31:0] pcPlus4;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [4:0]  destAddr;
	logic        isLink;
	logic        taken;
	exWbT        exWbNext;

	assign ctrl = idEx.ctrl;
	assign opA  = idEx.reg1;

	////////////////////////////////////////
	// Operand select and ALU
	////////////////////////////////////////
	// andi and ori take the immediate zero-extended
	assign logicalImm = {16'd0, idEx.imm[15:0]};

	always_comb
	begin
		if (!ctrl.aluSrc)
			opB = idEx.reg2;
		else if (ctrl.aluOp inside {aluAnd, aluOr, aluXor})
			opB = logicalImm;
		else
			opB = idEx.imm;
	end

	always_comb
	begin
		case (ctrl.aluOp)
			aluAdd:  aluResult = opA + opB;
			aluSub:  aluResult = opA - opB;
			aluAnd:  aluResult = opA & opB;
			aluOr:   aluResult = opA | opB;
			aluXor:  aluResult = opA ^ opB;
			aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
			// Immediate into the upper half
			aluLui:  aluResult = {opB[15:0], 16'd0};
			default: aluResult = opB;
		endcase
	end

	// jal writes the link register
	assign isLink = ctrl.isJump && ctrl.isNotConditional && ctrl.regWrite;

	always_comb
	begin
		if (isLink)
			destAddr = linkRegister;
		else if (ctrl.regDst)
			destAddr = idEx.rd;
		else
			destAddr = idEx.rt;
	end

	////////////////////////////////////////
	// Branch and jump resolution
	////////////////////////////////////////
	assign pcPlus4      = idEx.pc + 32'd4;
	assign branchTarget = pcPlus4 + {idEx.imm[29:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], idEx.jumpIndex, 2'b00};
	// beq taken on equal, bne on unequal
	assign taken = ctrl.isJump
		&& (ctrl.isNotConditional || ((idEx.reg1 == idEx.reg2) == ctrl.isEq));

	always_comb
	begin
		exWbNext.regWrite   = ctrl.regWrite;
		exWbNext.memRead    = ctrl.memRead;
		exWbNext.memWrite   = ctrl.memWrite;
		exWbNext.wbSel      = ctrl.wbSel;
		exWbNext.writeAddr  = destAddr;
		exWbNext.aluResult  = aluResult;
		exWbNext.storeData  = idEx.reg2;
		exWbNext.linkPc     = pcPlus4;
		exWbNext.redirect   = taken;
		exWbNext.redirectPc = ctrl.isNotConditional ? jumpTarget : branchTarget;
	end

	// EX/WB register
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			exWb <= '0;
		else
			exWb <= exWbNext;
	end

endmodule

// File: design/idExCore.sv
`timescale 1ns/1ps

module idExCore import idExPkg::*; (
	input  logic        clock,
	input  logic        arstN,
	input  logic [31:0] instr,
	input  logic [31:0] pcIn,
	input  logic [31:0] loadData,
	output logic        memRead,
	output logic        memWrite,
	output logic [31:0] memAddr,
	output logic [31:0] memWriteData,
	output logic        redirect,
	output logic [31:0] redirectPc,
	output logic        wbWrite,
	output logic [4:0]  wbAddr,
	output logic [31:0] wbData
);

	idExT idEx;
	exWbT exWb;

	// Decode and register read, write-back port
	decodeStage decodeStage_i (
		.clock    (clock),
		.arstN    (arstN),
		.instr    (instr),
		.pc       (pcIn),
		.exWb     (exWb),
		.loadData (loadData),
		.idEx     (idEx),
		.wbWrite  (wbWrite),
		.wbAddr   (wbAddr),
		.wbData   (wbData)
	);

	// ALU and branch resolution
	executeStage executeStage_i (
		.clock (clock),
		.arstN (arstN),
		.idEx  (idEx),
		.exWb  (exWb)
	);

	// Memory request from EX/WB
	assign memRead      = exWb.memRead;
	assign memWrite     = exWb.memWrite;
	assign memAddr      = exWb.aluResult;
	assign memWriteData = exWb.storeData;

	// Fetch redirect
	assign redirect   = exWb.redirect;
	assign redirectPc = exWb.redirectPc;

endmodule

// File: verif/idExCore_asserts.sv
`timescale 1ns/1ps

module idExCore_asserts import idExPkg::*; (
	input logic       clock,
	input logic       arstN,
	input logic       memRead,
	input logic       memWrite,
	input logic       redirect,
	input logic       wbWrite,
	input logic [4:0] wbAddr,
	input idExT       idEx
);

	// One memory request kind per cycle
	assert property (@(posedge clock) disable iff (!arstN) !(memRead && memWrite))
		else $error("memRead and memWrite high together");

	// r0 write must not reach operands read in that cycle
	assert property (@(posedge clock) disable iff (!arstN)
		(wbWrite && wbAddr == 5'd0) |=>
		((idEx.rs != 5'd0 || idEx.reg1 == 32'd0) && (idEx.rt != 5'd0 || idEx.reg2 == 32'd0)))
		else $error("nonzero operand read from r0 after a write to r0");

	// Strobes quiet in reset
	assert property (@(posedge clock) !arstN |-> !(memRead || memWrite || redirect || wbWrite))
		else $error("strobe high while in reset");

endmodule

bind idExCore idExCore_asserts asserts_i (
	.clock    (clock),
	.arstN    (arstN),
	.memRead  (memRead),
	.memWrite (memWrite),
	.redirect (redirect),
	.wbWrite  (wbWrite),
	.wbAddr   (wbAddr),
	.idEx     (idEx)
);

// File: verif/idExCoreTb.sv
`timescale 1ns/1ps

module idExCoreTb import idExPkg::*; ();

	typedef enum {strobeWb, strobeLoad, strobeStore, strobeRedirect} strobeT;

	logic        clock;
	logic        arstN;
	logic [31:0] instr;
	logic [31:0] pcIn;
	logic [31:0] loadData;
	logic        memRead;
	logic        memWrite;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;
	logic        redirect;
	logic [31:0] redirectPc;
	logic        wbWrite;
	logic [4:0]  wbAddr;
	logic [31:0] wbData;

	// Register model and stimulus state
	logic [31:0] regModel [32];
	logic [15:0] lfsrState;
	logic [31:0] pcNext;
	logic [31:0] lastPc;
	logic [31:0] followQ [$];
	int          errorCount;
	int          timeoutCount;

	idExCore dut_i (
		.clock        (clock),
		.arstN        (arstN),
		.instr        (instr),
		.pcIn         (pcIn),
		.loadData     (loadData),
		.memRead      (memRead),
		.memWrite     (memWrite),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.redirect     (redirect),
		.redirectPc   (redirectPc),
		.wbWrite      (wbWrite),
		.wbAddr       (wbAddr),
		.wbData       (wbData)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////
	// Galois LFSR, one step per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		logic        outBit;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			outBit    = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (outBit)
				lfsrState = lfsrState ^ 16'hB400;
			value = {value[30:0], outBit};
		end
		return value;
	endfunction

	function automatic logic [31:0] encodeR(input functT fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input opcodeT op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeJ(input opcodeT op, input logic [25:0] index);
		return {op, index};
	endfunction

	// Expected R-type result, slt signed
	function automatic logic [31:0] expectR(input functT fn, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] result;
		case (fn)
			fnAdd:   result = a + b;
			fnSub:   result = a - b;
			fnAnd:   result = a & b;
			fnOr:    result = a | b;
			fnXor:   result = a ^ b;
			default: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
		return result;
	endfunction

	// Logical immediates zero-extended, the rest sign-extended
	function automatic logic [31:0] expectI(input opcodeT op, input logic [31:0] a,
		input logic [15:0] imm);
		logic [31:0] ext;
		logic [31:0] result;
		ext = {{16{imm[15]}}, imm};
		case (op)
			opAndi:  result = a & {16'd0, imm};
			opOri:   result = a | {16'd0, imm};
			opSlti:  result = ($signed(a) < $signed(ext)) ? 32'd1 : 32'd0;
			opLui:   result = {imm, 16'd0};
			default: result = a + ext;
		endcase
		return result;
	endfunction

	function automatic bit strobeValue(input strobeT sel);
		case (sel)
			strobeWb:    return wbWrite;
			strobeLoad:  return memRead;
			strobeStore: return memWrite;
			default:     return redirect;
		endcase
	endfunction

	// Queued follow-on word or a no-op
	task automatic driveNext();
		logic [31:0] word;
		word = 32'd0;
		if (followQ.size() > 0)
			word = followQ.pop_front();
		instr  <= word;
		pcIn   <= pcNext;
		pcNext = pcNext + 32'd4;
	endtask

	task automatic issue(input logic [31:0] word);
		@(posedge clock);
		instr  <= word;
		pcIn   <= pcNext;
		lastPc = pcNext;
		pcNext = pcNext + 32'd4;
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	// Strobe two edges after the issue edge
	task automatic waitStrobe(input strobeT sel, input bit checkLatency, output bit found);
		int cycles;
		found  = 1'b0;
		cycles = 0;
		while (!found && cycles < 20)
		begin
			@(posedge clock);
			driveNext();
			@(negedge clock);
			found = strobeValue(sel);
			cycles++;
		end
		if (!found)
		begin
			$display("Timeout: no %s strobe seen within 20 cycles", sel.name());
			timeoutCount++;
		end
		else if (checkLatency && cycles != 2)
		begin
			$display("[FAIL] %0t: %s came after %0d edges", $time, sel.name(), cycles);
			errorCount++;
		end
	endtask

	task automatic expectWrite(input logic [4:0] addr, input logic [31:0] data,
		input bit checkLatency);
		bit found;
		waitStrobe(strobeWb, checkLatency, found);
		if (found)
		begin
			checkValue("wbAddr", {27'd0, wbAddr}, {27'd0, addr});
			checkValue("wbData", wbData, data);
			// Register zero keeps its zero
			if (addr != 5'd0)
				regModel[addr] = data;
		end
	endtask

	task automatic expectQuiet(input int cycles);
		repeat (cycles)
		begin
			@(posedge clock);
			driveNext();
			@(negedge clock);
			if (wbWrite || memRead || memWrite || redirect)
			begin
				$display("[FAIL] %0t: strobe raised where none was expected", $time);
				errorCount++;
			end
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	// A live jal on the input must not get past a held reset
	task automatic resetTest();
		@(posedge clock);
		instr <= encodeJ(opJal, 26'd1);
		repeat (4)
		begin
			@(negedge clock);
			if (wbWrite || memRead || memWrite || redirect)
			begin
				$display("[FAIL] %0t: strobe raised while in reset", $time);
				errorCount++;
			end
			@(posedge clock);
		end
		arstN <= 1'b1;
		instr <= 32'd0;
		expectQuiet(4);
	endtask

	// Random values into r1..r7 by lui then ori
	task automatic loadTest();
		logic [31:0] value;
		for (logic [4:0] r = 5'd1; r <= 5'd7; r++)
		begin
			value = randomBits(32);
			issue(encodeI(opLui, 5'd0, r, value[31:16]));
			expectWrite(r, {value[31:16], 16'd0}, 1'b1);
			issue(encodeI(opOri, r, r, value[15:0]));
			expectWrite(r, expectI(opOri, regModel[r], value[15:0]), 1'b1);
		end
	endtask

	task automatic aluTest();
		functT       fns [6];
		opcodeT      ops [4];
		logic [4:0]  dest;
		logic [15:0] imm;
		fns = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSlt};
		ops = '{opAddi, opAndi, opOri, opSlti};
		for (int i = 0; i < 6; i++)
		begin
			dest = 5'(10 + i);
			issue(encodeR(fns[i], 5'd1, 5'd2, dest));
			expectWrite(dest, expectR(fns[i], regModel[1], regModel[2]), 1'b1);
		end
		// slt the other way round
		issue(encodeR(fnSlt, 5'd2, 5'd1, 5'd16));
		expectWrite(5'd16, expectR(fnSlt, regModel[2], regModel[1]), 1'b1);
		for (int i = 0; i < 4; i++)
		begin
			dest = 5'(17 + i);
			imm  = 16'(randomBits(16));
			issue(encodeI(ops[i], 5'd3, dest, imm));
			expectWrite(dest, expectI(ops[i], regModel[3], imm), 1'b1);
		end
	endtask

	// Consumer one gap behind its producer
	task automatic bypassTest();
		followQ.push_back(32'd0);
		followQ.push_back(encodeR(fnSub, 5'd20, 5'd3, 5'd21));
		issue(encodeR(fnAdd, 5'd1, 5'd2, 5'd20));
		expectWrite(5'd20, expectR(fnAdd, regModel[1], regModel[2]), 1'b1);
		expectWrite(5'd21, expectR(fnSub, regModel[20], regModel[3]), 1'b0);
	endtask

	task automatic zeroTest();
		followQ.push_back(32'd0);
		followQ.push_back(encodeR(fnAdd, 5'd0, 5'd0, 5'd23));
		issue(encodeI(opAddi, 5'd1, 5'd0, 16'd5));
		expectWrite(5'd0, regModel[1] + 32'd5, 1'b1);
		// Bypass must not leak the r0 write
		expectWrite(5'd23, 32'd0, 1'b0);
		issue(encodeR(fnOr, 5'd0, 5'd2, 5'd22));
		expectWrite(5'd22, regModel[2], 1'b1);
	endtask

	task automatic memTest();
		logic [15:0] offset;
		logic [31:0] address;
		logic [31:0] data;
		bit          found;
		offset  = 16'(randomBits(16));
		address = regModel[4] + {{16{offset[15]}}, offset};
		issue(encodeI(opSw, 5'd4, 5'd5, offset));
		waitStrobe(strobeStore, 1'b1, found);
		if (found)
		begin
			checkValue("memAddr", memAddr, address);
			checkValue("memWriteData", memWriteData, regModel[5]);
			if (wbWrite || memRead)
			begin
				$display("[FAIL] %0t: store raised wbWrite or memRead", $time);
				errorCount++;
			end
		end
		offset  = 16'(randomBits(16));
		address = regModel[6] + {{16{offset[15]}}, offset};
		data    = randomBits(32);
		issue(encodeI(opLw, 5'd6, 5'd24, offset));
		loadData <= data;
		waitStrobe(strobeLoad, 1'b1, found);
		if (found)
		begin
			checkValue("memAddr", memAddr, address);
			checkValue("wbData", wbData, data);
			if (!wbWrite || wbAddr != 5'd24)
			begin
				$display("[FAIL] %0t: load write-back to r24 missing", $time);
				errorCount++;
			end
			regModel[24] = data;
		end
	endtask

	// Taken or not from the model values
	task automatic branchCase(input opcodeT op, input logic [4:0] rs, input logic [4:0] rt);
		logic [15:0] offset;
		logic [31:0] target;
		bit          taken;
		bit          found;
		offset = 16'(randomBits(16));
		taken  = (regModel[rs] == regModel[rt]) == (op == opBeq);
		issue(encodeI(op, rs, rt, offset));
		target = lastPc + 32'd4 + {{14{offset[15]}}, offset, 2'b00};
		if (taken)
		begin
			waitStrobe(strobeRedirect, 1'b1, found);
			if (found)
				checkValue("redirectPc", redirectPc, target);
		end
		else
		begin
			expectQuiet(4);
		end
	endtask

	task automatic jumpCase(input opcodeT op);
		logic [25:0] index;
		logic [31:0] pcPlus4;
		logic [31:0] target;
		bit          found;
		index = 26'(randomBits(26));
		issue(encodeJ(op, index));
		pcPlus4 = lastPc + 32'd4;
		target  = {pcPlus4[31:28], index, 2'b00};
		waitStrobe(strobeRedirect, 1'b1, found);
		if (found)
		begin
			checkValue("redirectPc", redirectPc, target);
			if (op == opJal)
			begin
				if (!wbWrite || wbAddr != 5'd31)
				begin
					$display("[FAIL] %0t: jal did not write r31", $time);
					errorCount++;
				end
				checkValue("link wbData", wbData, pcPlus4);
				regModel[31] = pcPlus4;
			end
			else if (wbWrite)
			begin
				$display("[FAIL] %0t: j raised wbWrite", $time);
				errorCount++;
			end
		end
	endtask

	task automatic branchTest();
		// r8 copies r6 for the equal cases
		issue(encodeR(fnOr, 5'd6, 5'd0, 5'd8));
		expectWrite(5'd8, regModel[6], 1'b1);
		branchCase(opBeq, 5'd6, 5'd8);
		branchCase(opBeq, 5'd6, 5'd7);
		branchCase(opBne, 5'd6, 5'd7);
		branchCase(opBne, 5'd6, 5'd8);
		jumpCase(opJ);
		jumpCase(opJal);
	endtask

	task automatic unknownTest();
		issue({6'h3f, 26'(randomBits(26))});
		expectQuiet(4);
		issue({6'h01, 26'(randomBits(26))});
		expectQuiet(4);
	endtask

	initial
	begin
		arstN        = 1'b0;
		instr        = '0;
		pcIn         = '0;
		loadData     = '0;
		lfsrState    = 16'd18441;
		pcNext       = 32'h0040_0000;
		lastPc       = '0;
		errorCount   = 0;
		timeoutCount = 0;
		foreach (regModel[i])
			regModel[i] = '0;
		resetTest();
		loadTest();
		aluTest();
		bypassTest();
		zeroTest();
		memTest();
		branchTest();
		unknownTest();
		$display("Value errors: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: filelist.f
design/idExPkg.sv
design/controlDecoder.sv
design/registerFile.sv
design/decodeStage.sv
design/executeStage.sv
design/idExCore.sv
verif/idExCore_asserts.sv
verif/idExCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module idExCoreTb -f filelist.f || exit 1
result="$(./obj_dir/VidExCoreTb)"
echo "$result"
echo "$result" | grep -qx "Test completed successfully" && exit 0 || exit 1
